//--- link8b10b.f
+incdir+src
src/line_code_pkg.sv
src/csr_pkg.sv
src/enc_8b10b.sv
src/dec_8b10b.sv
src/link_csr.sv
src/link8b10b_top.sv
tests/tb_link8b10b.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_link8b10b -f link8b10b.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_link8b10b 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- src/csr_pkg.sv
package csr_pkg;

	// register select, in the order of the byte offsets
	typedef enum logic [1:0] {
		reg_tx = 2'd0,
		reg_rx = 2'd1,
		reg_status = 2'd2,
		reg_errcnt = 2'd3
	} csr_reg_t;

	// AXI4-Lite response codes used by the slave
	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_t;

	// write channel waits in wr_resp until the response is taken
	typedef enum logic {wr_idle, wr_resp} wr_state_t;
	// read channel waits in rd_data until the data is taken
	typedef enum logic {rd_idle, rd_data} rd_state_t;

endpackage

//--- src/dec_8b10b.sv
`timescale 1ns/1ps
`include "link8b10b_config.svh"

module dec_8b10b (
	input  logic clk,
	input  logic rst,
	input  logic valid,
	input  line_code_pkg::code_group_t din,
	output line_code_pkg::byte_t dout,
	output logic k,
	output logic code_err,
	output logic disp_err,
	output logic done
);
	import line_code_pkg::*;

	// the 6b halves of the two commas are the two K28 sub-blocks
	localparam code_group_t comma_p = `COMMA_P;
	localparam code_group_t comma_n = `COMMA_N;

	rd_t rd_q, rd6, rd_next;
	logic [5:0] sb6;
	logic [3:0] sb4, sb4_k;
	logic [4:0] edcba;
	logic [2:0] hgf;
	logic [2:0] ones6, ones4;
	logic [3:0] ones;
	logic bad6, bad4, a7, a7_ok, k28, kx7, run_err;
	logic err6, err4, code_err_c;

	assign sb6 = din[9:4];
	assign sb4 = din[3:0];
	assign k28 = (sb6 == comma_p[9:4]) || (sb6 == comma_n[9:4]);
	// after 110000 the fghj half of a K28 is sent complemented
	assign sb4_k = (sb6 == comma_n[9:4]) ? ~sb4 : sb4;

	// abcdei back to EDCBA, both disparity forms on one line
	always_comb begin
		bad6 = 1'b0;
		case (sb6)
			6'b100111, 6'b011000: edcba = 5'd0;
			6'b011101, 6'b100010: edcba = 5'd1;
			6'b101101, 6'b010010: edcba = 5'd2;
			6'b110001: edcba = 5'd3;
			6'b110101, 6'b001010: edcba = 5'd4;
			6'b101001: edcba = 5'd5;
			6'b011001: edcba = 5'd6;
			6'b111000, 6'b000111: edcba = 5'd7;
			6'b111001, 6'b000110: edcba = 5'd8;
			6'b100101: edcba = 5'd9;
			6'b010101: edcba = 5'd10;
			6'b110100: edcba = 5'd11;
			6'b001101: edcba = 5'd12;
			6'b101100: edcba = 5'd13;
			6'b011100: edcba = 5'd14;
			6'b010111, 6'b101000: edcba = 5'd15;
			6'b011011, 6'b100100: edcba = 5'd16;
			6'b100011: edcba = 5'd17;
			6'b010011: edcba = 5'd18;
			6'b110010: edcba = 5'd19;
			6'b001011: edcba = 5'd20;
			6'b101010: edcba = 5'd21;
			6'b011010: edcba = 5'd22;
			6'b111010, 6'b000101: edcba = 5'd23;
			6'b110011, 6'b001100: edcba = 5'd24;
			6'b100110: edcba = 5'd25;
			6'b010110: edcba = 5'd26;
			6'b110110, 6'b001001: edcba = 5'd27;
			// D28 data, the K28 forms follow further down
			6'b001110: edcba = 5'd28;
			6'b101110, 6'b010001: edcba = 5'd29;
			6'b011110, 6'b100001: edcba = 5'd30;
			6'b101011, 6'b010100: edcba = 5'd31;
			6'b001111, 6'b110000: edcba = 5'd28;
			default: begin
				edcba = 5'd0;
				bad6 = 1'b1;
			end
		endcase
	end

	// fghj back to HGF, the alternate 7 is marked for the legality check
	always_comb begin
		bad4 = 1'b0;
		a7 = 1'b0;
		case (sb4_k)
			4'b1011, 4'b0100: hgf = 3'd0;
			4'b1001: hgf = 3'd1;
			4'b0101: hgf = 3'd2;
			4'b1100, 4'b0011: hgf = 3'd3;
			4'b1101, 4'b0010: hgf = 3'd4;
			4'b1010: hgf = 3'd5;
			4'b0110: hgf = 3'd6;
			4'b1110, 4'b0001: hgf = 3'd7;
			4'b0111, 4'b1000: begin
				hgf = 3'd7;
				a7 = 1'b1;
			end
			default: begin
				hgf = 3'd0;
				bad4 = 1'b1;
			end
		endcase
	end

	// K23, K27, K29 and K30 only exist as .7 with the alternate code
	assign kx7 = a7 && (edcba == 5'd23 || edcba == 5'd27 || edcba == 5'd29 || edcba == 5'd30);
	// data only uses A7 where P7 would make a run of five
	assign a7_ok = k28 || kx7 || edcba == 5'd11 || edcba == 5'd13 || edcba == 5'd14 ||
		edcba == 5'd17 || edcba == 5'd18 || edcba == 5'd20;

	// six equal bits in a row never occur inside a legal group
	always_comb begin
		run_err = 1'b0;
		for (int i = 0; i < 5; i++) begin
			if (din[i +: 6] == 6'b111111 || din[i +: 6] == 6'b000000) begin
				run_err = 1'b1;
			end
		end
	end

	assign ones6 = 3'($countones(sb6));
	assign ones4 = 3'($countones(sb4));
	assign ones = {1'b0, ones6} + {1'b0, ones4};
	assign code_err_c = bad6 | bad4 | (ones < 4'd4) | (ones > 4'd6) | run_err | (a7 & ~a7_ok);

	// an unbalanced sub-block must lean against the disparity it enters with
	// and then sets the disparity to its own sign, which also resyncs after errors
	assign err6 = (ones6 > 3'd3 && rd_q == rd_pos) || (ones6 < 3'd3 && rd_q == rd_neg);
	assign rd6 = (ones6 > 3'd3) ? rd_pos : (ones6 < 3'd3) ? rd_neg : rd_q;
	assign err4 = (ones4 > 3'd2 && rd6 == rd_pos) || (ones4 < 3'd2 && rd6 == rd_neg);
	assign rd_next = (ones4 > 3'd2) ? rd_pos : (ones4 < 3'd2) ? rd_neg : rd6;

	always_ff @(posedge clk) begin
		if (!rst) begin
			rd_q <= rd_neg;
			done <= 1'b0;
		end else begin
			done <= valid;
			if (valid) begin
				rd_q <= rd_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (valid) begin
			dout <= {hgf, edcba};
			k <= k28 | kx7;
			code_err <= code_err_c;
			disp_err <= err6 | err4;
		end
	end

endmodule

//--- src/enc_8b10b.sv
`timescale 1ns/1ps
`include "link8b10b_config.svh"

module enc_8b10b (
	input  logic clk,
	input  logic rst,
	input  logic ena,
	input  logic k,
	input  line_code_pkg::byte_t din,
	output line_code_pkg::code_group_t dout
);
	import line_code_pkg::*;

	rd_t rd_q;
	code_group_t code_q;
	logic disp_in, disp6, disp_out;
	logic ai, bi, ci, di, ei, fi, gi, hi;
	logic aeqb, ceqd, l22, l40, l04, l13, l31;
	logic a_enc, b_enc, c_enc, d_enc, e_enc, i_enc;
	logic f_enc, g_enc, h_enc, j_enc;
	logic pd1s6, nd1s6, ndos6, pdos6, alt7;
	logic pd1s4, nd1s4, ndos4, pdos4;
	logic compls6, compls4;

	assign disp_in = (rd_q == rd_pos);
	assign {hi, gi, fi, ei, di, ci, bi, ai} = din;

	// classify abcd by how many ones it holds
	assign aeqb = ai ~^ bi;
	assign ceqd = ci ~^ di;
	assign l22 = (ai & bi & ~ci & ~di) | (ci & di & ~ai & ~bi) | (~aeqb & ~ceqd);
	assign l40 = ai & bi & ci & di;
	assign l04 = ~(ai | bi | ci | di);
	assign l13 = (~aeqb & ~ci & ~di) | (~ceqd & ~ai & ~bi);
	assign l31 = (~aeqb & ci & di) | (~ceqd & ai & bi);

	// 5b/6b sub-block in its primary form, before any complement
	assign a_enc = ai;
	assign b_enc = (bi & ~l40) | l04;
	assign c_enc = l04 | ci | (ei & di & ~ci & ~bi & ~ai);
	assign d_enc = di & ~(ai & bi & ci);
	assign e_enc = (ei | l13) & ~(ei & di & ~ci & ~bi & ~ai);
	// the k term only matters for K28, the other K codes already set i
	assign i_enc = (l22 & ~ei) | (ei & ~di & ~ci & ~(ai & bi)) | (ei & l40) |
		(k & ei & di & ci & ~bi & ~ai) | (ei & ~di & ci & ~bi & ~ai);

	// pd1s6 marks primary forms that assume a positive disparity before them
	// and nd1s6 those that assume a negative one
	assign pd1s6 = (ei & di & ~ci & ~bi & ~ai) | (~ei & ~l22 & ~l31);
	assign nd1s6 = k | (ei & ~l22 & ~l13) | (~ei & ~di & ci & bi & ai);
	// which of those leave the sub-block unbalanced and so flip the disparity
	assign ndos6 = pd1s6;
	assign pdos6 = k | (ei & ~l22 & ~l13);

	// Dx.7 would give a run of five across e, i, f, g, h for D17, D18, D20
	// at negative disparity and for D11, D13, D14 at positive disparity
	// so those use the alternate 7, as do all Kx.7 symbols
	// the 6b half of these is balanced, so disparity on entry still holds
	assign alt7 = fi & gi & hi & (k | (disp_in ? (~ei & di & l31) : (ei & ~di & l13)));

	// 3b/4b sub-block in its primary form
	assign f_enc = fi & ~alt7;
	assign g_enc = gi | (~fi & ~gi & ~hi);
	assign h_enc = hi;
	assign j_enc = (~hi & (gi ^ fi)) | alt7;

	// K28.1, .2, .5 and .6 take the complement even though they are balanced
	assign nd1s4 = fi & gi;
	assign pd1s4 = (~fi & ~gi) | (k & (fi ^ gi));
	assign ndos4 = ~fi & ~gi;
	assign pdos4 = fi & gi & hi;

	// the 4b half sees the disparity left behind by the 6b half
	assign compls6 = (pd1s6 & ~disp_in) | (nd1s6 & disp_in);
	assign disp6 = disp_in ^ (ndos6 | pdos6);
	assign compls4 = (pd1s4 & ~disp6) | (nd1s4 & disp6);
	assign disp_out = disp6 ^ (ndos4 | pdos4);

	// the line sits on a comma until the first symbol is sent
	always_ff @(posedge clk) begin
		if (!rst) begin
			rd_q <= rd_neg;
			code_q <= `COMMA_N;
		end else if (ena) begin
			rd_q <= disp_out ? rd_pos : rd_neg;
			code_q <= {a_enc ^ compls6, b_enc ^ compls6, c_enc ^ compls6,
				d_enc ^ compls6, e_enc ^ compls6, i_enc ^ compls6,
				f_enc ^ compls4, g_enc ^ compls4, h_enc ^ compls4, j_enc ^ compls4};
		end
	end

	assign dout = code_q;

endmodule

//--- src/line_code_pkg.sv
package line_code_pkg;

	// one data or control byte, bit 0 is the A bit of the 5b/6b sub-block
	typedef logic [7:0] byte_t;

	// one 10-bit code group on the line
	// bit 9 carries a and goes out first, bit 0 carries j
	// bits 9..4 are the abcdei sub-block and bits 3..0 the fghj sub-block
	typedef logic [9:0] code_group_t;

	// running disparity between code groups and between sub-blocks
	typedef enum logic {
		rd_neg = 1'b0,
		rd_pos = 1'b1
	} rd_t;

endpackage

//--- src/link8b10b_config.svh
`ifndef LINK8B10B_CONFIG_SVH
`define LINK8B10B_CONFIG_SVH

// K28.5 as sent when the running disparity on entry is negative
`define COMMA_P 10'b0011111010
// K28.5 as sent when the running disparity on entry is positive
`define COMMA_N 10'b1100000101

// register bus address width, word registers at byte offsets
`define CSR_ADDR_W 4

// byte offsets of the four registers
`define REG_TX_OFS 4'h0
`define REG_RX_OFS 4'h4
`define REG_STATUS_OFS 4'h8
`define REG_ERRCNT_OFS 4'hc

`endif

//--- src/link8b10b_top.sv
`timescale 1ns/1ps
`include "link8b10b_config.svh"

module link8b10b_top (
	input  logic clk,
	input  logic rst,
	input  logic [`CSR_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output csr_pkg::axi_resp_t bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`CSR_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output csr_pkg::axi_resp_t rresp,
	output logic rvalid,
	input  logic rready,
	output line_code_pkg::code_group_t tx_code,
	output logic tx_code_valid,
	input  line_code_pkg::code_group_t rx_code,
	input  logic rx_code_valid
);
	import line_code_pkg::*;

	byte_t tx_byte, rx_byte;
	logic tx_k, tx_ena;
	logic rx_k, rx_code_err, rx_disp_err, rx_done;

	link_csr i_csr (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.tx_byte(tx_byte), .tx_k(tx_k), .tx_ena(tx_ena),
		.rx_byte(rx_byte), .rx_k(rx_k), .rx_code_err(rx_code_err),
		.rx_disp_err(rx_disp_err), .rx_done(rx_done)
	);

	enc_8b10b i_enc (
		.clk(clk), .rst(rst), .ena(tx_ena), .k(tx_k), .din(tx_byte), .dout(tx_code)
	);

	dec_8b10b i_dec (
		.clk(clk), .rst(rst), .valid(rx_code_valid), .din(rx_code),
		.dout(rx_byte), .k(rx_k), .code_err(rx_code_err),
		.disp_err(rx_disp_err), .done(rx_done)
	);

	// the encoder output register lags its enable by one cycle
	always_ff @(posedge clk) begin
		if (!rst) begin
			tx_code_valid <= 1'b0;
		end else begin
			tx_code_valid <= tx_ena;
		end
	end

endmodule

//--- src/link_csr.sv
`timescale 1ns/1ps
`include "link8b10b_config.svh"

module link_csr (
	input  logic clk,
	input  logic rst,
	input  logic [`CSR_ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [31:0] wdata,
	// byte strobes are not supported, every write is taken as a full word
	input  logic [3:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output csr_pkg::axi_resp_t bresp,
	output logic bvalid,
	input  logic bready,
	input  logic [`CSR_ADDR_W-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output csr_pkg::axi_resp_t rresp,
	output logic rvalid,
	input  logic rready,
	output line_code_pkg::byte_t tx_byte,
	output logic tx_k,
	output logic tx_ena,
	input  line_code_pkg::byte_t rx_byte,
	input  logic rx_k,
	input  logic rx_code_err,
	input  logic rx_disp_err,
	input  logic rx_done
);
	import csr_pkg::*;

	wr_state_t wr_state;
	rd_state_t rd_state;
	csr_reg_t wr_sel, rd_sel;
	logic wr_hit, rd_hit, wr_ok;
	logic wr_fire, rd_fire, rx_read, cnt_clear;
	logic rx_ready, overflow;
	logic [10:0] rx_q;
	logic [15:0] err_cnt;
	logic [31:0] rd_word;

	// hit is cleared for any offset outside the register map
	function automatic csr_reg_t addr_decode(input logic [`CSR_ADDR_W-1:0] addr,
		output logic hit);
		hit = 1'b1;
		case (addr)
			`REG_TX_OFS: addr_decode = reg_tx;
			`REG_RX_OFS: addr_decode = reg_rx;
			`REG_STATUS_OFS: addr_decode = reg_status;
			`REG_ERRCNT_OFS: addr_decode = reg_errcnt;
			default: begin
				addr_decode = reg_tx;
				hit = 1'b0;
			end
		endcase
	endfunction

	always_comb begin
		wr_sel = addr_decode(awaddr, wr_hit);
		rd_sel = addr_decode(araddr, rd_hit);
	end

	// address and data are only taken together, and only while no response waits
	assign wr_fire = (wr_state == wr_idle) && awvalid && wvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign bvalid = (wr_state == wr_resp);
	// RX and STATUS are read only
	assign wr_ok = wr_hit && (wr_sel == reg_tx || wr_sel == reg_errcnt);
	assign cnt_clear = wr_fire && wr_ok && (wr_sel == reg_errcnt);

	// the read address is only taken while no read data waits
	assign rd_fire = (rd_state == rd_idle) && arvalid;
	assign arready = rd_fire;
	assign rvalid = (rd_state == rd_data);
	assign rx_read = rd_fire && rd_hit && (rd_sel == reg_rx);

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_state <= wr_idle;
			rd_state <= rd_idle;
			tx_ena <= 1'b0;
		end else begin
			// one encoder strobe per accepted TX write, in step with bvalid
			tx_ena <= wr_fire && wr_ok && (wr_sel == reg_tx);
			if (wr_state == wr_idle && wr_fire) begin
				wr_state <= wr_resp;
			end else if (wr_state == wr_resp && bready) begin
				wr_state <= wr_idle;
			end
			if (rd_state == rd_idle && rd_fire) begin
				rd_state <= rd_data;
			end else if (rd_state == rd_data && rready) begin
				rd_state <= rd_idle;
			end
		end
	end

	always_comb begin
		rd_word = '0;
		case (rd_sel)
			reg_tx: rd_word[8:0] = {tx_k, tx_byte};
			reg_rx: rd_word[10:0] = rx_q;
			reg_status: rd_word[1:0] = {overflow, rx_ready};
			reg_errcnt: rd_word[15:0] = err_cnt;
		endcase
	end

	// response and data stay put while the master holds off ready
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= wr_ok ? resp_okay : resp_slverr;
			if (wr_ok && wr_sel == reg_tx) begin
				tx_byte <= wdata[7:0];
				tx_k <= wdata[8];
			end
		end
		if (rd_fire) begin
			rresp <= rd_hit ? resp_okay : resp_slverr;
			rdata <= rd_hit ? rd_word : '0;
		end
		if (rx_done) begin
			rx_q <= {rx_disp_err, rx_code_err, rx_k, rx_byte};
		end
	end

	// a new symbol wins over a read of RX in the same cycle
	always_ff @(posedge clk) begin
		if (!rst) begin
			rx_ready <= 1'b0;
			overflow <= 1'b0;
			err_cnt <= '0;
		end else begin
			if (rx_done) begin
				rx_ready <= 1'b1;
				overflow <= rx_ready && !rx_read;
			end else if (rx_read) begin
				rx_ready <= 1'b0;
				overflow <= 1'b0;
			end
			if (cnt_clear) begin
				err_cnt <= '0;
			end else if (rx_done && (rx_code_err || rx_disp_err) && err_cnt != 16'hffff) begin
				err_cnt <= err_cnt + 16'd1;
			end
		end
	end

endmodule

//--- tests/tb_link8b10b.sv
`timescale 1ns/1ps
`include "link8b10b_config.svh"

module tb_link8b10b;
	import line_code_pkg::*;
	import csr_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int N_RAND = 16;

	logic clk, rst;
	logic [`CSR_ADDR_W-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	code_group_t tx_code, rx_code, rx_code_drv;
	logic tx_code_valid, rx_code_valid, rx_valid_drv, loop_break;

	// reference model state, the running disparity of the transmit side
	rd_t model_rd;
	int errors = 0;
	int cyc = 0;
	int last_wr_cyc;
	int n_rows = 0;

	// stimulus table: {k, byte}, {inject enable, raw group}, expected {disp_err, code_err}
	logic [8:0] row_sym[$];
	logic [10:0] row_inj[$];
	logic [1:0] row_err[$];

	// every tx_code_valid strobe seen, with the cycle it was seen in
	code_group_t pulse_code[$];
	int pulse_cyc[$];

	// 5b/6b groups for negative running disparity, indexed by EDCBA
	logic [5:0] tbl6 [0:31] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	// 3b/4b groups for negative disparity after the 6b half, data and control
	logic [3:0] tbl4_d [0:7] = '{4'b1011, 4'b1001, 4'b0101, 4'b1100,
		4'b1101, 4'b1010, 4'b0110, 4'b1110};
	logic [3:0] tbl4_k [0:7] = '{4'b1011, 4'b0110, 4'b1010, 4'b1100,
		4'b1101, 4'b0101, 4'b1001, 4'b0111};

	link8b10b_top i_dut (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.tx_code(tx_code), .tx_code_valid(tx_code_valid),
		.rx_code(rx_code), .rx_code_valid(rx_code_valid)
	);

	// the receive port normally listens to the transmit port
	assign rx_code = loop_break ? rx_code_drv : tx_code;
	assign rx_code_valid = loop_break ? rx_valid_drv : tx_code_valid;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// sampled mid-cycle, where the encoder output is stable
	always @(negedge clk) begin
		if (rst && tx_code_valid) begin
			pulse_code.push_back(tx_code);
			pulse_cyc.push_back(cyc);
		end
	end

	initial begin
		wait (n_rows > 0);
		#((50 * n_rows + 600) * CLK_PERIOD);
		$display("timeout: the test sequence did not finish within %0d cycles", 50 * n_rows + 600);
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// table lookup encoder, complements the negative disparity forms where needed
	task automatic encode_ref(input logic [8:0] sym, output code_group_t code);
		logic [4:0] x;
		logic [2:0] y;
		logic k, rd6, alt;
		logic [5:0] s6;
		logic [3:0] s4;
		x = sym[4:0];
		y = sym[7:5];
		k = sym[8];
		s6 = (k && x == 5'd28) ? 6'b001111 : tbl6[x];
		// D7 is balanced but still has a second form
		if (model_rd == rd_pos && ($countones(s6) != 3 || x == 5'd7)) begin
			s6 = ~s6;
		end
		rd6 = (model_rd == rd_pos) ^ ($countones(s6) != 3);
		// A7 avoids a run of five ones or zeros across the sub-block border
		alt = (y == 3'd7) && (k || (!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
		s4 = k ? tbl4_k[y] : (alt ? 4'b0111 : tbl4_d[y]);
		// only the balanced data forms .1 .2 .5 .6 have a single spelling
		if (rd6 && (k || alt || !(y == 3'd1 || y == 3'd2 || y == 3'd5 || y == 3'd6))) begin
			s4 = ~s4;
		end
		model_rd = (rd6 ^ ($countones(s4) != 2)) ? rd_pos : rd_neg;
		code = {s6, s4};
	endtask

	task automatic add_row(input logic [8:0] sym, input logic [10:0] inj, input logic [1:0] err);
		row_sym.push_back(sym);
		row_inj.push_back(inj);
		row_err.push_back(err);
	endtask

	// hold keeps bready low for that many cycles while the response waits
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] resp);
		logic accepted;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (hold == 0);
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = awready && wready;
			last_wr_cyc = cyc;
			@(posedge clk);
			#1;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		check_value("bvalid", 32'(bvalid), 32'd1);
		resp = bresp;
		repeat (hold) begin
			@(posedge clk);
			#1;
			@(negedge clk);
			check_value("bvalid held", 32'(bvalid), 32'd1);
			check_value("bresp held", 32'(bresp), 32'(resp));
		end
		if (hold > 0) begin
			@(posedge clk);
			#1;
			bready = 1'b1;
			@(negedge clk);
			check_value("bvalid held", 32'(bvalid), 32'd1);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic read_reg(input logic [3:0] addr, input int hold, output logic [31:0] data,
		output logic [1:0] resp);
		logic accepted;
		araddr = addr;
		arvalid = 1'b1;
		rready = (hold == 0);
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = arready;
			@(posedge clk);
			#1;
		end
		arvalid = 1'b0;
		@(negedge clk);
		check_value("rvalid", 32'(rvalid), 32'd1);
		data = rdata;
		resp = rresp;
		repeat (hold) begin
			@(posedge clk);
			#1;
			@(negedge clk);
			check_value("rvalid held", 32'(rvalid), 32'd1);
			check_value("rdata held", rdata, data);
			check_value("rresp held", 32'(rresp), 32'(resp));
		end
		if (hold > 0) begin
			@(posedge clk);
			#1;
			rready = 1'b1;
			@(negedge clk);
			check_value("rvalid held", 32'(rvalid), 32'd1);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic read_check(input logic [3:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] d;
		logic [1:0] r;
		read_reg(addr, 0, d, r);
		check_value({name, " rresp"}, 32'(r), 32'(resp_okay));
		check_value(name, d, exp);
	endtask

	// polls STATUS until one of the bits in mask is set
	task automatic wait_status(input logic [1:0] mask, output logic [31:0] status);
		logic [31:0] d;
		logic [1:0] r;
		d = '0;
		while ((d[1:0] & mask) == 2'b00) begin
			read_reg(`REG_STATUS_OFS, 0, d, r);
			check_value("STATUS rresp", 32'(r), 32'(resp_okay));
		end
		status = d;
	endtask

	task automatic send_raw_group(input code_group_t code);
		loop_break = 1'b1;
		rx_code_drv = code;
		rx_valid_drv = 1'b1;
		@(posedge clk);
		#1;
		rx_valid_drv = 1'b0;
	endtask

	initial begin
		logic [31:0] d, status, lfsr, last_rx;
		logic [1:0] r;
		logic [7:0] rb;
		code_group_t exp_code, code_a, code_b;
		rd_t rd_before;
		int exp_errcnt;
		int hs_a;
		rst = 1'b0;
		awaddr = '0;
		araddr = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b1;
		rready = 1'b1;
		loop_break = 1'b1;
		rx_code_drv = '0;
		rx_valid_drv = 1'b0;
		model_rd = rd_neg;
		exp_errcnt = 0;
		last_rx = '0;

		// data groups, including the ones that may take the alternate 7
		add_row(9'h000, 11'h0, 2'b00);
		add_row(9'h0ff, 11'h0, 2'b00);
		add_row(9'h0f1, 11'h0, 2'b00);
		add_row(9'h0eb, 11'h0, 2'b00);
		add_row(9'h0f4, 11'h0, 2'b00);
		add_row(9'h0ed, 11'h0, 2'b00);
		add_row(9'h0ee, 11'h0, 2'b00);
		add_row(9'h007, 11'h0, 2'b00);
		add_row(9'h0e7, 11'h0, 2'b00);
		add_row(9'h04a, 11'h0, 2'b00);
		add_row(9'h063, 11'h0, 2'b00);
		// K28.5 twice, so the comma goes out at both disparities
		add_row(9'h1bc, 11'h0, 2'b00);
		add_row(9'h1bc, 11'h0, 2'b00);
		add_row(9'h11c, 11'h0, 2'b00);
		add_row(9'h13c, 11'h0, 2'b00);
		add_row(9'h15c, 11'h0, 2'b00);
		add_row(9'h17c, 11'h0, 2'b00);
		add_row(9'h19c, 11'h0, 2'b00);
		add_row(9'h1dc, 11'h0, 2'b00);
		add_row(9'h1fc, 11'h0, 2'b00);
		add_row(9'h1f7, 11'h0, 2'b00);
		add_row(9'h1fb, 11'h0, 2'b00);
		add_row(9'h1fd, 11'h0, 2'b00);
		add_row(9'h1fe, 11'h0, 2'b00);
		lfsr = 32'h0accd6aa;
		for (int j = 0; j < N_RAND; j++) begin
			for (int b = 0; b < 8; b++) begin
				lfsr = lfsr_step(lfsr);
				rb[b] = lfsr[0];
			end
			add_row({1'b0, rb}, 11'h0, 2'b00);
		end
		// all zeros breaks every rule and leaves the decoder at negative disparity
		add_row(9'h000, {1'b1, 10'b0000000000}, 2'b11);
		// D0.0 in its positive disparity form arrives while the decoder is negative
		add_row(9'h000, {1'b1, 10'b0110001011}, 2'b10);
		n_rows = row_sym.size();

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		loop_break = 1'b0;

		@(negedge clk);
		check_value("tx_code", 32'(tx_code), 32'(`COMMA_N));
		check_value("tx_code_valid", 32'(tx_code_valid), 32'd0);
		check_value("awready", 32'(awready), 32'd0);
		check_value("wready", 32'(wready), 32'd0);
		check_value("arready", 32'(arready), 32'd0);
		check_value("bvalid", 32'(bvalid), 32'd0);
		check_value("rvalid", 32'(rvalid), 32'd0);
		@(posedge clk);
		#1;
		read_check(`REG_STATUS_OFS, 32'h0, "STATUS");
		read_check(`REG_ERRCNT_OFS, 32'h0, "ERRCNT");

		// two symbols arrive before RX is read, the second one must remain
		pulse_code.delete();
		pulse_cyc.delete();
		encode_ref(9'h001, code_a);
		encode_ref(9'h0aa, code_b);
		write_reg(`REG_TX_OFS, 32'h001, 0, r);
		check_value("TX bresp", 32'(r), 32'(resp_okay));
		hs_a = last_wr_cyc;
		write_reg(`REG_TX_OFS, 32'h0aa, 0, r);
		check_value("TX bresp", 32'(r), 32'(resp_okay));
		wait_status(2'b10, status);
		check_value("STATUS", status, 32'h3);
		check_value("tx_code_valid count", 32'(pulse_code.size()), 32'd2);
		check_value("tx_code_valid delay", 32'(pulse_cyc[0] - hs_a), 32'd2);
		check_value("tx_code", 32'(pulse_code[0]), 32'(code_a));
		check_value("tx_code", 32'(pulse_code[1]), 32'(code_b));
		read_check(`REG_RX_OFS, 32'h0aa, "RX");
		read_check(`REG_STATUS_OFS, 32'h0, "STATUS");

		for (int i = 0; i < n_rows; i++) begin
			pulse_code.delete();
			pulse_cyc.delete();
			if (!row_inj[i][10]) begin
				rd_before = model_rd;
				encode_ref(row_sym[i], exp_code);
				write_reg(`REG_TX_OFS, {23'd0, row_sym[i]}, 0, r);
				check_value("TX bresp", 32'(r), 32'(resp_okay));
				wait_status(2'b01, status);
				check_value("STATUS", status, 32'h1);
				check_value("tx_code_valid count", 32'(pulse_code.size()), 32'd1);
				check_value("tx_code_valid delay", 32'(pulse_cyc[0] - last_wr_cyc), 32'd2);
				check_value("tx_code", 32'(pulse_code[0]), 32'(exp_code));
				check_value("tx_code ones in range",
					32'($countones(pulse_code[0]) >= 4 && $countones(pulse_code[0]) <= 6), 32'd1);
				if (row_sym[i] == 9'h1bc) begin
					check_value("K28.5 tx_code", 32'(pulse_code[0]),
						(rd_before == rd_neg) ? 32'(`COMMA_P) : 32'(`COMMA_N));
				end
			end else begin
				send_raw_group(row_inj[i][9:0]);
				wait_status(2'b01, status);
				check_value("STATUS", status, 32'h1);
			end
			read_reg(`REG_RX_OFS, 0, d, r);
			check_value("RX rresp", 32'(r), 32'(resp_okay));
			check_value("RX error bits", 32'(d[10:9]), 32'(row_err[i]));
			// the byte of a group with a code error means nothing
			if (!row_err[i][0]) begin
				check_value("RX byte and K", 32'(d[8:0]), 32'(row_sym[i]));
			end
			last_rx = d;
			if (row_err[i] != 2'b00) begin
				exp_errcnt++;
			end
			read_check(`REG_ERRCNT_OFS, 32'(exp_errcnt), "ERRCNT");
			read_check(`REG_STATUS_OFS, 32'h0, "STATUS");
		end

		write_reg(`REG_ERRCNT_OFS, 32'h0, 0, r);
		check_value("ERRCNT bresp", 32'(r), 32'(resp_okay));
		read_check(`REG_ERRCNT_OFS, 32'h0, "ERRCNT");

		// error responses, two of them with the master stalling the response
		pulse_code.delete();
		read_reg(4'h2, 4, d, r);
		check_value("unmapped rresp", 32'(r), 32'(resp_slverr));
		check_value("unmapped rdata", d, 32'h0);
		write_reg(`REG_STATUS_OFS, 32'h3, 4, r);
		check_value("STATUS bresp", 32'(r), 32'(resp_slverr));
		write_reg(`REG_RX_OFS, 32'h1ff, 0, r);
		check_value("RX bresp", 32'(r), 32'(resp_slverr));
		write_reg(4'h6, 32'h1bc, 0, r);
		check_value("unmapped bresp", 32'(r), 32'(resp_slverr));
		read_reg(`REG_ERRCNT_OFS, 3, d, r);
		check_value("ERRCNT rresp", 32'(r), 32'(resp_okay));
		check_value("ERRCNT", d, 32'h0);
		check_value("tx_code_valid count", 32'(pulse_code.size()), 32'd0);
		read_check(`REG_STATUS_OFS, 32'h0, "STATUS");
		read_check(`REG_RX_OFS, last_rx, "RX");

		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
